// File: bench/mem_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;

  logic                   i_clock = 1'b0;
  logic                   i_rst;
  logic                   i_req_valid;
  mem_op_pkg::mem_op_e    i_req_op;
  logic [6:0]             i_req_base;
  logic [6:0]             i_req_offset;
  logic [31:0]            i_req_wdata;
  logic                   i_rsp_ready;
  wire                    o_req_ready;
  wire                    o_misaligned;
  wire                    o_rsp_valid;
  wire  [31:0]            o_rsp_data;

  logic [31:0] lfsr_q = 32'h71e4_c211;  // Shared random source
  logic [7:0]  model_mem [128];          // Byte model of the RAM in big-endian order
  logic [31:0] exp_q [$];                // Expected load results in order
  logic        mis_expect = 1'b0;        // o_misaligned due next cycle
  logic        held_valid = 1'b0;        // Response seen but not taken
  logic [31:0] held_data;
  logic        seen_ready_low = 1'b0;
  logic        draining = 1'b0;          // End phase with the response port always ready
  int          stall_left = 0;
  int          mis_count = 0;
  int          waited;

  mem_stage_top uut (
    .i_clock, .i_rst, .i_req_valid, .i_req_op, .i_req_base, .i_req_offset, .i_req_wdata,
    .o_req_ready, .o_misaligned, .o_rsp_valid, .o_rsp_data, .i_rsp_ready
  );

  always #10 i_clock = ~i_clock;  // 20 ns period

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // One step per bit
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic value_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic stop_on_timeout(input string msg);
    $display("Timeout: %s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic misaligned_addr(input logic [6:0] a,
                                           input mem_op_pkg::access_size_e sz);
    if (sz == mem_op_pkg::SIZE_HALF) return a[0];
    if (sz == mem_op_pkg::SIZE_WORD) return a[1:0] != 2'b00;
    return 1'b0;
  endfunction

  // Model bytes assembled MSB first and then extended
  function automatic logic [31:0] model_load(input logic [6:0] a,
                                             input mem_op_pkg::access_size_e sz,
                                             input logic sgn);
    logic [15:0] h;
    h = {model_mem[a], model_mem[a + 7'd1]};
    case (sz)
      mem_op_pkg::SIZE_BYTE: return {{24{sgn & model_mem[a][7]}}, model_mem[a]};
      mem_op_pkg::SIZE_HALF: return {{16{sgn & h[15]}}, h};
      default: return {h, model_mem[a + 7'd2], model_mem[a + 7'd3]};
    endcase
  endfunction

  task automatic model_store(input logic [6:0] a, input mem_op_pkg::access_size_e sz,
                             input logic [31:0] d);
    case (sz)
      mem_op_pkg::SIZE_BYTE: model_mem[a] = d[7:0];
      mem_op_pkg::SIZE_HALF: begin
        model_mem[a]        = d[15:8];
        model_mem[a + 7'd1] = d[7:0];
      end
      default: for (int i = 0; i < 4; i++) model_mem[a + 7'(i)] = d[31 - 8*i -: 8];
    endcase
  endtask

  // One clock and then i_rsp_ready driven 1 ns after the edge
  task automatic step_cycle();
    logic [31:0] r;
    @(posedge i_clock);
    #1;
    if (draining) begin
      i_rsp_ready = 1'b1;
    end else if (stall_left > 0) begin
      stall_left--;
      i_rsp_ready = 1'b0;
    end else begin
      draw_bits(4, r);
      if (r[3:0] == 4'd0) begin  // Long back-pressure stretch
        draw_bits(5, r);
        stall_left = 15 + int'(r[4:0]);
        i_rsp_ready = 1'b0;
      end else begin
        i_rsp_ready = (r[1:0] != 2'b00);
      end
    end
  endtask

  task automatic issue_request(input logic first);
    logic [31:0]              r;
    logic [6:0]               target;
    logic                     mis;
    logic                     accepted;
    mem_op_pkg::mem_op_e      op;
    mem_op_pkg::access_size_e sz;
    draw_bits(2, r);
    repeat (r[1:0]) step_cycle();  // Idle gap
    draw_bits(3, r);
    op = first ? mem_op_pkg::LW : mem_op_pkg::mem_op_e'(r[2:0]);
    draw_bits(3, r);
    mis = (r[2:0] == 3'd0) && !first;  // About one in eight
    if (mis && mem_op_pkg::op_size(op) == mem_op_pkg::SIZE_BYTE)
      op = mem_op_pkg::op_is_store(op) ? mem_op_pkg::SH : mem_op_pkg::LH;
    sz = mem_op_pkg::op_size(op);
    draw_bits(7, r);
    target = r[6:0];
    draw_bits(2, r);
    if (sz == mem_op_pkg::SIZE_HALF) target[0] = mis;
    else if (sz == mem_op_pkg::SIZE_WORD)
      target[1:0] = !mis ? 2'd0 : (r[1:0] == 0) ? 2'd3 : r[1:0];
    draw_bits(7, r);
    i_req_base   = r[6:0];
    i_req_offset = target - r[6:0];  // Base plus offset wraps to target
    draw_bits(32, i_req_wdata);
    i_req_op     = op;
    i_req_valid  = 1'b1;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted) begin
      @(negedge i_clock);
      accepted = o_req_ready;  // Taken at the coming edge
      step_cycle();
      waited++;
      if (!accepted && waited > 500) stop_on_timeout("request never accepted");
    end
    i_req_valid = 1'b0;
  endtask

  // Checks and model updates on the falling edge where outputs are settled
  always @(negedge i_clock) begin
    logic [6:0]               a;
    mem_op_pkg::access_size_e sz;
    if (!i_rst) begin
      assert (o_misaligned == mis_expect) else value_error("o_misaligned differs from model");
      mis_expect = 1'b0;
      // Queue plus one load in flight bounds the outstanding loads
      assert (exp_q.size() <= mem_cfg_pkg::QUEUE_DEPTH + (o_req_ready ? 0 : 1))
        else value_error($sformatf("%0d loads outstanding with ready %b",
                                   exp_q.size(), o_req_ready));
      if (held_valid)
        assert (o_rsp_valid && o_rsp_data == held_data) else value_error("held response changed");
      if (o_rsp_valid && i_rsp_ready) begin
        assert (exp_q.size() > 0) else value_error("response without a pending load");
        assert (o_rsp_data == exp_q[0])
          else value_error($sformatf("load data %h, expected %h", o_rsp_data, exp_q[0]));
        void'(exp_q.pop_front());
      end
      held_valid = o_rsp_valid && !i_rsp_ready;
      held_data  = o_rsp_data;
      if (!o_req_ready) seen_ready_low = 1'b1;
      if (i_req_valid && o_req_ready) begin  // Accepted at the next edge
        a  = i_req_base + i_req_offset;
        sz = mem_op_pkg::op_size(i_req_op);
        if (misaligned_addr(a, sz)) begin
          mis_expect = 1'b1;
          mis_count++;
        end else if (mem_op_pkg::op_is_store(i_req_op)) begin
          model_store(a, sz, i_req_wdata);
        end else begin
          exp_q.push_back(model_load(a, sz, mem_op_pkg::op_is_signed(i_req_op)));
        end
      end
    end
  end

  initial begin
    for (int i = 0; i < 128; i++) model_mem[i] = 8'h00;
    i_rst        = 1'b1;
    i_req_valid  = 1'b0;
    i_req_op     = mem_op_pkg::LB;
    i_req_base   = '0;
    i_req_offset = '0;
    i_req_wdata  = '0;
    i_rsp_ready  = 1'b0;
    repeat (5) @(posedge i_clock);
    #1 i_rst = 1'b0;
    @(negedge i_clock);
    assert (o_req_ready && !o_rsp_valid && !o_misaligned)
      else value_error("bad state after reset");
    step_cycle();
    for (int n = 0; n < 600; n++) issue_request(n == 0);  // First is a load of cleared RAM
    draining = 1'b1;
    waited = 0;
    while (exp_q.size() != 0 || o_rsp_valid) begin
      step_cycle();
      waited++;
      if (waited > 200) stop_on_timeout("pending loads never returned");
    end
    repeat (4) step_cycle();  // Catch stray responses or pulses
    assert (seen_ready_low) else value_error("o_req_ready never fell under back-pressure");
    assert (mis_count > 0) else value_error("no misaligned request was issued");
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/mem_op_pkg.sv
rtl/mem_cfg_pkg.sv
rtl/mem_request_issuer.sv
rtl/mem_request_queue.sv
rtl/data_memory.sv
rtl/mem_access_unit.sv
rtl/mem_stage_top.sv
bench/mem_stage_tb.sv

// File: rtl/data_memory.sv
`timescale 1ns/10ps
`default_nettype none

module data_memory (
  input  wire                             i_clock,
  input  wire                             i_mem_write,
  input  wire                             i_mem_read,
  input  mem_op_pkg::access_size_e        i_size,
  input  wire [mem_cfg_pkg::ADDR_W-1:0]   i_address,
  input  wire [mem_cfg_pkg::DATA_W-1:0]   i_write_data,
  output logic [mem_cfg_pkg::DATA_W-1:0]  o_read_data  // Valid one cycle after read
);

  // Byte array, big-endian: most significant byte at the lowest address
  logic [7:0] ram [mem_cfg_pkg::MEM_BYTES];

  logic [mem_cfg_pkg::ADDR_W-1:0] addr1;
  logic [mem_cfg_pkg::ADDR_W-1:0] addr2;
  logic [mem_cfg_pkg::ADDR_W-1:0] addr3;

  assign addr1 = i_address + mem_cfg_pkg::ADDR_W'(1);
  assign addr2 = i_address + mem_cfg_pkg::ADDR_W'(2);
  assign addr3 = i_address + mem_cfg_pkg::ADDR_W'(3);

  // Contents start cleared
  initial begin
    for (int i = 0; i < mem_cfg_pkg::MEM_BYTES; i++)
      ram[i] = 8'h00;
  end

  // Byte-lane writes taken from the low end of the write data
  always @(posedge i_clock) begin
    if (i_mem_write) begin
      case (i_size)
        mem_op_pkg::SIZE_BYTE: begin
          ram[i_address] <= i_write_data[7:0];
        end
        mem_op_pkg::SIZE_HALF: begin
          ram[i_address] <= i_write_data[15:8];
          ram[addr1]     <= i_write_data[7:0];
        end
        mem_op_pkg::SIZE_WORD: begin
          ram[i_address] <= i_write_data[31:24];
          ram[addr1]     <= i_write_data[23:16];
          ram[addr2]     <= i_write_data[15:8];
          ram[addr3]     <= i_write_data[7:0];
        end
        default: ;  // Unused size code writes nothing
      endcase
    end
  end

  // Registered read, upper bytes zero for narrow sizes
  always_ff @(posedge i_clock) begin
    if (i_mem_read) begin
      case (i_size)
        mem_op_pkg::SIZE_BYTE:
          o_read_data <= {{(mem_cfg_pkg::DATA_W-8){1'b0}}, ram[i_address]};
        mem_op_pkg::SIZE_HALF:
          o_read_data <= {{(mem_cfg_pkg::DATA_W-16){1'b0}}, ram[i_address], ram[addr1]};
        default:
          o_read_data <= {ram[i_address], ram[addr1], ram[addr2], ram[addr3]};
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_access_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access_unit (
  input  wire                             i_clock,
  input  wire                             i_rst,
  // Head of the request queue
  input  wire                             i_pop_valid,
  input  wire [mem_cfg_pkg::ADDR_W-1:0]   i_pop_addr,
  input  mem_op_pkg::access_size_e        i_pop_size,
  input  wire                             i_pop_signed,
  input  wire                             i_pop_store,
  input  wire [mem_cfg_pkg::DATA_W-1:0]   i_pop_wdata,
  output logic                            o_pop,
  output logic                            o_credit_return,
  // RAM side
  output logic                            o_mem_write,
  output logic                            o_mem_read,
  output mem_op_pkg::access_size_e        o_mem_size,
  output logic [mem_cfg_pkg::ADDR_W-1:0]  o_mem_addr,
  output logic [mem_cfg_pkg::DATA_W-1:0]  o_mem_wdata,
  input  wire  [mem_cfg_pkg::DATA_W-1:0]  i_read_data,
  // External response port
  output logic                            o_rsp_valid,
  output logic [mem_cfg_pkg::DATA_W-1:0]  o_rsp_data,
  input  wire                             i_rsp_ready
);

  typedef enum logic [1:0] {IDLE, LOAD_WAIT, RSP_HOLD} state_e;

  state_e                   state_q;
  logic                     pop_store;
  logic                     pop_load;
  mem_op_pkg::access_size_e ld_size_q;    // Size of the load in flight
  logic                     ld_signed_q;

  function automatic logic [mem_cfg_pkg::DATA_W-1:0] extend(
    input logic [mem_cfg_pkg::DATA_W-1:0] d,
    input mem_op_pkg::access_size_e       s,
    input logic                           sgn
  );
    case (s)
      mem_op_pkg::SIZE_BYTE: return {{(mem_cfg_pkg::DATA_W-8){sgn & d[7]}}, d[7:0]};
      mem_op_pkg::SIZE_HALF: return {{(mem_cfg_pkg::DATA_W-16){sgn & d[15]}}, d[15:0]};
      default:               return d;
    endcase
  endfunction

  // Stores may go any time, a load only with an empty slot and nothing in flight
  assign pop_store = i_pop_valid && i_pop_store;
  assign pop_load  = i_pop_valid && !i_pop_store && (state_q == IDLE);

  assign o_pop           = pop_store || pop_load;
  assign o_credit_return = o_pop;  // Entry freed, give the credit back

  // RAM driven straight from the head entry
  assign o_mem_write = pop_store;
  assign o_mem_read  = pop_load;
  assign o_mem_size  = i_pop_size;
  assign o_mem_addr  = i_pop_addr;
  assign o_mem_wdata = i_pop_wdata;

  assign o_rsp_valid = (state_q == RSP_HOLD);

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:      if (pop_load) state_q <= LOAD_WAIT;
        LOAD_WAIT: state_q <= RSP_HOLD;           // Read data arrives now
        RSP_HOLD:  if (i_rsp_ready) state_q <= IDLE;
        default:   state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clock) begin
    if (pop_load) begin
      ld_size_q   <= i_pop_size;
      ld_signed_q <= i_pop_signed;
    end
    // Slot loaded once, then held until the transfer
    if (state_q == LOAD_WAIT)
      o_rsp_data <= extend(i_read_data, ld_size_q, ld_signed_q);
  end

endmodule

`default_nettype wire

// File: rtl/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

  localparam int DATA_W = 32;  // Load/store data width

  localparam int ADDR_W = 7;   // Byte address, 128 bytes

  localparam int MEM_BYTES = 128;

  // Queue entries, also the issuer's starting credit count
  localparam int QUEUE_DEPTH = 4;

  localparam int CREDIT_W = 3;  // Holds 0..QUEUE_DEPTH

endpackage

`default_nettype wire

// File: rtl/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

  // Load/store opcodes, loads first
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LBU = 3'd1,
    LH  = 3'd2,
    LHU = 3'd3,
    LW  = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } mem_op_e;

  // Access width in bytes: 1, 2 or 4
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  function automatic logic op_is_store(input mem_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  // Only LB, LH and LW sign-extend; stores report unsigned
  function automatic logic op_is_signed(input mem_op_e op);
    return (op == LB) || (op == LH) || (op == LW);
  endfunction

  function automatic access_size_e op_size(input mem_op_e op);
    case (op)
      LB, LBU, SB: return SIZE_BYTE;
      LH, LHU, SH: return SIZE_HALF;
      default:     return SIZE_WORD;  // LW, SW
    endcase
  endfunction

endpackage

`default_nettype wire

// File: rtl/mem_request_issuer.sv
`timescale 1ns/10ps
`default_nettype none

module mem_request_issuer (
  input  wire                              i_clock,
  input  wire                              i_rst,
  // External request port
  input  wire                              i_req_valid,
  input  mem_op_pkg::mem_op_e              i_req_op,
  input  wire [mem_cfg_pkg::ADDR_W-1:0]    i_req_base,
  input  wire [mem_cfg_pkg::ADDR_W-1:0]    i_req_offset,
  input  wire [mem_cfg_pkg::DATA_W-1:0]    i_req_wdata,
  output logic                             o_req_ready,
  output logic                             o_misaligned,
  // Push side of the request queue
  output logic                             o_push,
  output logic [mem_cfg_pkg::ADDR_W-1:0]   o_push_addr,
  output mem_op_pkg::access_size_e         o_push_size,
  output logic                             o_push_signed,
  output logic                             o_push_store,
  output logic [mem_cfg_pkg::DATA_W-1:0]   o_push_wdata,
  input  wire                              i_credit_return  // One per pop
);

  logic [mem_cfg_pkg::ADDR_W-1:0]   eff_addr;
  mem_op_pkg::access_size_e         req_size;
  logic                             bad_align;
  logic                             accept;
  logic                             spend;      // Aligned accept takes a credit
  logic [mem_cfg_pkg::CREDIT_W-1:0] credit_q;

  // Effective address wraps at 128 bytes
  assign eff_addr = i_req_base + i_req_offset;
  assign req_size = mem_op_pkg::op_size(i_req_op);

  // Halfword needs bit 0 clear, word needs bits 1:0 clear
  always_comb begin
    case (req_size)
      mem_op_pkg::SIZE_HALF: bad_align = eff_addr[0];
      mem_op_pkg::SIZE_WORD: bad_align = |eff_addr[1:0];
      default:               bad_align = 1'b0;
    endcase
  end

  assign accept = i_req_valid && o_req_ready;
  assign spend  = accept && !bad_align;

  assign o_req_ready = (credit_q != '0);  // Room left in the queue

  // Credit count: start full, minus aligned accepts, plus returns
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      credit_q <= mem_cfg_pkg::CREDIT_W'(mem_cfg_pkg::QUEUE_DEPTH);
    end else begin
      case ({spend, i_credit_return})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;  // Both or neither
      endcase
    end
  end

  // Push or misaligned pulse one cycle after acceptance
  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      o_push       <= 1'b0;
      o_misaligned <= 1'b0;
    end else begin
      o_push       <= spend;
      o_misaligned <= accept && bad_align;  // Dropped, nothing pushed
    end
  end

  // Decoded payload, only meaningful while o_push is high
  always_ff @(posedge i_clock) begin
    if (accept) begin
      o_push_addr   <= eff_addr;
      o_push_size   <= req_size;
      o_push_signed <= mem_op_pkg::op_is_signed(i_req_op);
      o_push_store  <= mem_op_pkg::op_is_store(i_req_op);
      o_push_wdata  <= i_req_wdata;
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_request_queue.sv
`timescale 1ns/10ps
`default_nettype none

module mem_request_queue (
  input  wire                             i_clock,
  input  wire                             i_rst,
  input  wire                             i_push,
  input  wire [mem_cfg_pkg::ADDR_W-1:0]   i_push_addr,
  input  mem_op_pkg::access_size_e        i_push_size,
  input  wire                             i_push_signed,
  input  wire                             i_push_store,
  input  wire [mem_cfg_pkg::DATA_W-1:0]   i_push_wdata,
  input  wire                             i_pop,
  output logic                            o_pop_valid,
  output logic [mem_cfg_pkg::ADDR_W-1:0]  o_pop_addr,
  output mem_op_pkg::access_size_e        o_pop_size,
  output logic                            o_pop_signed,
  output logic                            o_pop_store,
  output logic [mem_cfg_pkg::DATA_W-1:0]  o_pop_wdata
);

  // Entry storage, one array per field
  logic [mem_cfg_pkg::ADDR_W-1:0] addr_mem   [mem_cfg_pkg::QUEUE_DEPTH];
  mem_op_pkg::access_size_e       size_mem   [mem_cfg_pkg::QUEUE_DEPTH];
  logic                           signed_mem [mem_cfg_pkg::QUEUE_DEPTH];
  logic                           store_mem  [mem_cfg_pkg::QUEUE_DEPTH];
  logic [mem_cfg_pkg::DATA_W-1:0] wdata_mem  [mem_cfg_pkg::QUEUE_DEPTH];

  logic [$clog2(mem_cfg_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(mem_cfg_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(mem_cfg_pkg::QUEUE_DEPTH+1)-1:0] count;
  logic                                          do_pop;

  assign o_pop_valid = (count != '0);
  assign do_pop      = i_pop && o_pop_valid;  // Ignore pop on empty

  // Head entry, first-word-fall-through
  assign o_pop_addr   = addr_mem[rd_ptr];
  assign o_pop_size   = size_mem[rd_ptr];
  assign o_pop_signed = signed_mem[rd_ptr];
  assign o_pop_store  = store_mem[rd_ptr];
  assign o_pop_wdata  = wdata_mem[rd_ptr];

  always_ff @(posedge i_clock) begin
    if (i_push) begin  // Credits keep this from overflowing
      addr_mem[wr_ptr]   <= i_push_addr;
      size_mem[wr_ptr]   <= i_push_size;
      signed_mem[wr_ptr] <= i_push_signed;
      store_mem[wr_ptr]  <= i_push_store;
      wdata_mem[wr_ptr]  <= i_push_wdata;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push)
        wr_ptr <= (wr_ptr == mem_cfg_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == mem_cfg_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({i_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_stage_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top (
  input  wire                             i_clock,
  input  wire                             i_rst,
  input  wire                             i_req_valid,
  input  mem_op_pkg::mem_op_e             i_req_op,
  input  wire [mem_cfg_pkg::ADDR_W-1:0]   i_req_base,
  input  wire [mem_cfg_pkg::ADDR_W-1:0]   i_req_offset,
  input  wire [mem_cfg_pkg::DATA_W-1:0]   i_req_wdata,
  output logic                            o_req_ready,
  output logic                            o_misaligned,
  output logic                            o_rsp_valid,
  output logic [mem_cfg_pkg::DATA_W-1:0]  o_rsp_data,
  input  wire                             i_rsp_ready
);

  // Issuer to queue
  logic                           push;
  logic [mem_cfg_pkg::ADDR_W-1:0] push_addr;
  mem_op_pkg::access_size_e       push_size;
  logic                           push_signed;
  logic                           push_store;
  logic [mem_cfg_pkg::DATA_W-1:0] push_wdata;
  // Queue head to access unit
  logic                           pop;
  logic                           pop_valid;
  logic [mem_cfg_pkg::ADDR_W-1:0] pop_addr;
  mem_op_pkg::access_size_e       pop_size;
  logic                           pop_signed;
  logic                           pop_store;
  logic [mem_cfg_pkg::DATA_W-1:0] pop_wdata;
  logic                           credit_return;
  // Access unit to RAM
  logic                           mem_write;
  logic                           mem_read;
  mem_op_pkg::access_size_e       mem_size;
  logic [mem_cfg_pkg::ADDR_W-1:0] mem_addr;
  logic [mem_cfg_pkg::DATA_W-1:0] mem_wdata;
  logic [mem_cfg_pkg::DATA_W-1:0] read_data;

  mem_request_issuer u_issuer (
    .i_clock, .i_rst, .i_req_valid, .i_req_op, .i_req_base, .i_req_offset, .i_req_wdata,
    .o_req_ready, .o_misaligned,
    .o_push(push), .o_push_addr(push_addr), .o_push_size(push_size),
    .o_push_signed(push_signed), .o_push_store(push_store), .o_push_wdata(push_wdata),
    .i_credit_return(credit_return)
  );

  mem_request_queue u_queue (
    .i_clock, .i_rst,
    .i_push(push), .i_push_addr(push_addr), .i_push_size(push_size),
    .i_push_signed(push_signed), .i_push_store(push_store), .i_push_wdata(push_wdata),
    .i_pop(pop), .o_pop_valid(pop_valid), .o_pop_addr(pop_addr), .o_pop_size(pop_size),
    .o_pop_signed(pop_signed), .o_pop_store(pop_store), .o_pop_wdata(pop_wdata)
  );

  mem_access_unit u_access (
    .i_clock, .i_rst,
    .i_pop_valid(pop_valid), .i_pop_addr(pop_addr), .i_pop_size(pop_size),
    .i_pop_signed(pop_signed), .i_pop_store(pop_store), .i_pop_wdata(pop_wdata),
    .o_pop(pop), .o_credit_return(credit_return),
    .o_mem_write(mem_write), .o_mem_read(mem_read), .o_mem_size(mem_size),
    .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata), .i_read_data(read_data),
    .o_rsp_valid, .o_rsp_data, .i_rsp_ready
  );

  data_memory u_ram (
    .i_clock, .i_mem_write(mem_write), .i_mem_read(mem_read), .i_size(mem_size),
    .i_address(mem_addr), .i_write_data(mem_wdata), .o_read_data(read_data)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the memory stage testbench with Verilator, run it into sim.log,
# and pass only when the log holds the pass message
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module mem_stage_tb \
  -o mem_stage_sim \
  && ./obj_dir/mem_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
